//--- sir_settings.svh
`ifndef SIR_SETTINGS_SVH
`define SIR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Receiver timing
////////////////////////////////////////////////////////////

// Sample ticks per bit period
`define SIR_OVERSAMPLE 16

// Bits shifted in per frame, start and stop excluded
`define SIR_FRAME_BITS 9

// Clock divisor for the sample tick
`define SIR_DIV_WIDTH 16
`define SIR_DIV_RESET 4

////////////////////////////////////////////////////////////
// APB register map
////////////////////////////////////////////////////////////

`define SIR_APB_ADDR_WIDTH 8
`define SIR_APB_DATA_WIDTH 32

`define SIR_ADDR_CTRL   8'h00
`define SIR_ADDR_DIV    8'h04
`define SIR_ADDR_STATUS 8'h08
`define SIR_ADDR_DATA   8'h0C

`endif

//--- sir_pkg.sv
`include "sir_settings.svh"

package sir_pkg;

    // Receive FSM states, in walk order
    typedef enum logic [2:0]
    {
        IDLE  = 3'd0,
        START = 3'd1,
        BIT   = 3'd2,
        SHIFT = 3'd3,
        STOP  = 3'd4,
        SAVE  = 3'd5
    } sir_state_t;

    // Parity view of a received word, parity bit last in
    typedef struct packed
    {
        logic [7:0] data;
        logic       parity;
    } sir_word_par_t;

    // Same nine bits, raw or as byte plus parity
    typedef union packed
    {
        logic [`SIR_FRAME_BITS-1:0] raw;
        sir_word_par_t              pb;
    } sir_word_u;

    // CTRL register, bit 0 first from the bottom
    typedef struct packed
    {
        logic irq_en;
        logic parity_en;
        logic enable;
    } sir_ctrl_t;

    // STATUS register
    typedef struct packed
    {
        logic parity_err;
        logic frame_err;
        logic overrun;
        logic valid;
    } sir_status_t;

endpackage

//--- sir_seq_if.sv
`timescale 1ns/100ps

interface sir_seq_if;

    // Strobes from the FSM
    logic load_half;
    logic load_full;
    logic bit_clear;
    logic bit_step;
    logic shift_en;

    // Timer feedback
    logic tick_done;
    logic bits_done;

    // Synchronized serial line
    logic rxd_s;

    modport fsm
    (
        output load_half, load_full, bit_clear, bit_step, shift_en,
        input  tick_done, bits_done, rxd_s
    );

    modport timer
    (
        input  load_half, load_full, bit_clear, bit_step,
        output tick_done, bits_done
    );

    modport shifter
    (
        input  shift_en,
        output rxd_s
    );

endinterface

//--- sir_fsm.sv
`timescale 1ns/100ps

module sir_fsm
    import sir_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   enable,
    sir_seq_if.fsm seq,
    output logic   frame_valid,
    output logic   frame_err
);

    sir_state_t state;
    sir_state_t next_state;
    logic       rxd_prev;
    logic       stop_low;
    logic       start_edge;

    // Falling edge on the synchronized line
    assign start_edge = rxd_prev & ~seq.rxd_s;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= IDLE;
            rxd_prev <= 1'b1;
            stop_low <= 1'b0;
        end
        else
        begin
            state    <= next_state;
            rxd_prev <= seq.rxd_s;
            // Stop bit sampled at its middle
            if (state == STOP && seq.tick_done)
                stop_low <= ~seq.rxd_s;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and sequencing strobes
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state    = state;
        seq.load_half = 1'b0;
        seq.load_full = 1'b0;
        seq.bit_clear = 1'b0;
        seq.bit_step  = 1'b0;
        seq.shift_en  = 1'b0;
        case (state)
            IDLE:
            begin
                if (enable && start_edge)
                begin
                    next_state    = START;
                    seq.load_half = 1'b1;
                    seq.bit_clear = 1'b1;
                end
            end
            START:
            begin
                // Recheck at mid start bit, high means a glitch
                if (seq.tick_done)
                begin
                    if (!seq.rxd_s)
                    begin
                        next_state    = BIT;
                        seq.load_full = 1'b1;
                    end
                    else
                        next_state = IDLE;
                end
            end
            BIT:
            begin
                // Reload on the tick itself so no clocks are lost
                if (seq.tick_done)
                begin
                    next_state    = SHIFT;
                    seq.load_full = 1'b1;
                end
            end
            SHIFT:
            begin
                seq.shift_en = 1'b1;
                if (seq.bits_done)
                    next_state = STOP;
                else
                begin
                    seq.bit_step = 1'b1;
                    next_state   = BIT;
                end
            end
            STOP:
            begin
                if (seq.tick_done)
                    next_state = SAVE;
            end
            SAVE:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
        // Disabling drops any frame in progress
        if (!enable)
            next_state = IDLE;
    end

    assign frame_valid = (state == SAVE);
    assign frame_err   = (state == SAVE) & stop_low;

endmodule

//--- sir_timer.sv
`timescale 1ns/100ps

`include "sir_settings.svh"

module sir_timer
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`SIR_DIV_WIDTH-1:0] div,
    sir_seq_if.timer                  seq
);

    localparam int SMP_W = $clog2(`SIR_OVERSAMPLE);
    localparam int BIT_W = $clog2(`SIR_FRAME_BITS);
    localparam logic [SMP_W-1:0] HALF_LOAD = SMP_W'(`SIR_OVERSAMPLE / 2 - 1);
    localparam logic [SMP_W-1:0] FULL_LOAD = SMP_W'(`SIR_OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0] BIT_LOAD  = BIT_W'(`SIR_FRAME_BITS - 1);

    logic [`SIR_DIV_WIDTH-1:0] div_eff;
    logic [`SIR_DIV_WIDTH-1:0] pre_cnt;
    logic                      tick;
    logic                      load;
    logic [SMP_W-1:0]          smp_cnt;
    logic                      armed;
    logic [BIT_W-1:0]          bit_cnt;

    // Divisor of zero runs at the full clock rate
    assign div_eff = (div == '0) ? `SIR_DIV_WIDTH'(1) : div;
    assign tick    = (pre_cnt >= div_eff - 1'b1);
    assign load    = seq.load_half | seq.load_full;

    ////////////////////////////////////////////////////////////
    // Prescaler and oversample countdown
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            pre_cnt <= '0;
            smp_cnt <= '0;
            armed   <= 1'b0;
        end
        else
        begin
            // A load realigns the tick phase
            if (load || tick)
                pre_cnt <= '0;
            else
                pre_cnt <= pre_cnt + 1'b1;

            if (seq.load_half)
            begin
                smp_cnt <= HALF_LOAD;
                armed   <= 1'b1;
            end
            else if (seq.load_full)
            begin
                smp_cnt <= FULL_LOAD;
                armed   <= 1'b1;
            end
            else if (tick && armed)
            begin
                if (smp_cnt == '0)
                    armed <= 1'b0;
                else
                    smp_cnt <= smp_cnt - 1'b1;
            end
        end
    end

    assign seq.tick_done = tick & armed & (smp_cnt == '0);

    // Bits still to shift after the current one
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            bit_cnt <= BIT_LOAD;
        else if (seq.bit_clear)
            bit_cnt <= BIT_LOAD;
        else if (seq.bit_step && bit_cnt != '0)
            bit_cnt <= bit_cnt - 1'b1;
    end

    assign seq.bits_done = (bit_cnt == '0);

endmodule

//--- sir_shifter.sv
`timescale 1ns/100ps

`include "sir_settings.svh"

module sir_shifter
    import sir_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       rxd,
    sir_seq_if.shifter seq,
    output sir_word_u  word
);

    logic [1:0] sync_q;

    ////////////////////////////////////////////////////////////
    // Line synchronizer
    ////////////////////////////////////////////////////////////

    // Idle line is high, so the flops come out of reset high
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            sync_q <= 2'b11;
        else
            sync_q <= {sync_q[0], rxd};
    end

    assign seq.rxd_s = sync_q[1];

    ////////////////////////////////////////////////////////////
    // Shift register
    ////////////////////////////////////////////////////////////

    // New bit enters at the bottom, first bit ends up as MSB
    always_ff @(posedge clk)
    begin
        if (seq.shift_en)
            word.raw <= {word.raw[`SIR_FRAME_BITS-2:0], seq.rxd_s};
    end

endmodule

//--- sir_apb_regs.sv
`timescale 1ns/100ps

`include "sir_settings.svh"

module sir_apb_regs
    import sir_pkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [`SIR_APB_ADDR_WIDTH-1:0] paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`SIR_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`SIR_APB_DATA_WIDTH-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic                           frame_valid,
    input  logic                           frame_err,
    input  sir_word_u                      word,
    output sir_ctrl_t                      ctrl,
    output logic [`SIR_DIV_WIDTH-1:0]      div,
    output logic                           irq
);

    logic        access;
    logic        addr_hit;
    logic        wr_en;
    logic        rd_en;
    logic        data_rd;
    logic        par_bad;
    sir_status_t status_q;
    sir_status_t status_d;
    sir_status_t status_w1c;
    sir_word_u   data_q;

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////

    assign access = psel & penable;

    always_comb
    begin
        case (paddr)
            `SIR_ADDR_CTRL, `SIR_ADDR_DIV, `SIR_ADDR_STATUS, `SIR_ADDR_DATA:
                addr_hit = 1'b1;
            default:
                addr_hit = 1'b0;
        endcase
    end

    assign wr_en   = access & pwrite & addr_hit;
    assign rd_en   = access & ~pwrite & addr_hit;
    assign data_rd = rd_en & (paddr == `SIR_ADDR_DATA);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access & ~addr_hit;

    // Control and divisor
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            ctrl <= '0;
            div  <= `SIR_DIV_WIDTH'(`SIR_DIV_RESET);
        end
        else if (wr_en)
        begin
            if (paddr == `SIR_ADDR_CTRL)
                ctrl <= sir_ctrl_t'(pwdata[$bits(sir_ctrl_t)-1:0]);
            if (paddr == `SIR_ADDR_DIV)
                div <= pwdata[`SIR_DIV_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Received word and status flags
    ////////////////////////////////////////////////////////////

    // Even parity over the byte must match the trailing bit
    assign par_bad    = ctrl.parity_en & ((^word.pb.data) != word.pb.parity);
    assign status_w1c = sir_status_t'(pwdata[$bits(sir_status_t)-1:0]);

    always_comb
    begin
        status_d = status_q;
        // Error flags are write-one-to-clear, valid is read-only
        if (wr_en && paddr == `SIR_ADDR_STATUS)
        begin
            status_d.overrun    = status_q.overrun & ~status_w1c.overrun;
            status_d.frame_err  = status_q.frame_err & ~status_w1c.frame_err;
            status_d.parity_err = status_q.parity_err & ~status_w1c.parity_err;
        end
        if (data_rd)
            status_d.valid = 1'b0;
        // New frame wins over a clear in the same cycle
        if (frame_valid)
        begin
            status_d.valid      = 1'b1;
            status_d.overrun    = status_d.overrun | (status_q.valid & ~data_rd);
            status_d.frame_err  = status_d.frame_err | frame_err;
            status_d.parity_err = status_d.parity_err | par_bad;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            status_q <= '0;
        else
            status_q <= status_d;
    end

    // Held word, overwritten by every new frame
    always_ff @(posedge clk)
    begin
        if (frame_valid)
            data_q <= word;
    end

    // Read mux, unused bits read as zero
    always_comb
    begin
        prdata = '0;
        case (paddr)
            `SIR_ADDR_CTRL:
                prdata[$bits(sir_ctrl_t)-1:0] = ctrl;
            `SIR_ADDR_DIV:
                prdata[`SIR_DIV_WIDTH-1:0] = div;
            `SIR_ADDR_STATUS:
                prdata[$bits(sir_status_t)-1:0] = status_q;
            `SIR_ADDR_DATA:
            begin
                if (ctrl.parity_en)
                    prdata[7:0] = data_q.pb.data;
                else
                    prdata[`SIR_FRAME_BITS-1:0] = data_q.raw;
            end
            default:
                prdata = '0;
        endcase
    end

    assign irq = ctrl.irq_en & (|status_q);

endmodule

//--- sir_rx_top.sv
`timescale 1ns/100ps

`include "sir_settings.svh"

module sir_rx_top
    import sir_pkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [`SIR_APB_ADDR_WIDTH-1:0] paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`SIR_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`SIR_APB_DATA_WIDTH-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic                           rxd,
    output logic                           irq
);

    sir_ctrl_t                 ctrl;
    logic [`SIR_DIV_WIDTH-1:0] div;
    sir_word_u                 word;
    logic                      frame_valid;
    logic                      frame_err;

    // Sequencing between FSM, timer and shifter
    sir_seq_if seq_if ();

    sir_fsm sir_fsm_i
    (
        .clk         (clk),
        .rstn        (rstn),
        .enable      (ctrl.enable),
        .seq         (seq_if.fsm),
        .frame_valid (frame_valid),
        .frame_err   (frame_err)
    );

    sir_timer sir_timer_i
    (
        .clk  (clk),
        .rstn (rstn),
        .div  (div),
        .seq  (seq_if.timer)
    );

    sir_shifter sir_shifter_i
    (
        .clk  (clk),
        .rstn (rstn),
        .rxd  (rxd),
        .seq  (seq_if.shifter),
        .word (word)
    );

    sir_apb_regs sir_apb_regs_i
    (
        .clk         (clk),
        .rstn        (rstn),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_valid (frame_valid),
        .frame_err   (frame_err),
        .word        (word),
        .ctrl        (ctrl),
        .div         (div),
        .irq         (irq)
    );

endmodule

//--- tb_sir_rx.sv
`timescale 1ns/100ps

`include "sir_settings.svh"

module tb_sir_rx
    import sir_pkg::*;
();

    localparam int NUM_FRAMES  = 15;
    localparam int MAX_DIV     = 7;
    localparam int MARGIN_NS   = 400000;
    localparam int WATCHDOG_NS = NUM_FRAMES * 10 * `SIR_OVERSAMPLE * MAX_DIV * 40 + MARGIN_NS;
    localparam int POLL_LIMIT  = 200;

    logic                           clk;
    logic                           rstn;
    logic [`SIR_APB_ADDR_WIDTH-1:0] paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`SIR_APB_DATA_WIDTH-1:0] pwdata;
    logic [`SIR_APB_DATA_WIDTH-1:0] prdata;
    logic                           pready;
    logic                           pslverr;
    logic                           rxd;
    logic                           irq;

    integer     seed;
    int         cur_div;
    sir_state_t fsm_state;

    // FSM state shown when a frame never completes
    assign fsm_state = sir_rx_top_i.sir_fsm_i.state;

    sir_rx_top sir_rx_top_i
    (
        .clk     (clk),
        .rstn    (rstn),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rxd     (rxd),
        .irq     (irq)
    );

    always #20 clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
        end_in_failure();
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic end_in_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            end_in_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #2;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // Sampled mid-cycle away from the access edge
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_and_check(input logic [7:0] addr, input string name,
                                  input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_read(addr, rdata, err);
        check(name, rdata, expected);
        check({name, " pslverr"}, 32'(err), 0);
    endtask

    task automatic set_div(input int d);
        apb_write(`SIR_ADDR_DIV, d);
        cur_div = d;
    endtask

    // Polls STATUS until a word is reported
    task automatic wait_valid(output sir_status_t st);
        logic [31:0] rdata;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(`SIR_ADDR_STATUS, rdata, err);
        while (rdata[0] !== 1'b1)
        begin
            polls++;
            if (polls > POLL_LIMIT)
            begin
                $display("No valid word reported in time, FSM state is %s",
                         fsm_state.name());
                end_in_failure();
            end
            apb_read(`SIR_ADDR_STATUS, rdata, err);
        end
        st = sir_status_t'(rdata[3:0]);
    endtask

    ////////////////////////////////////////////////////////////
    // Serial line model
    ////////////////////////////////////////////////////////////

    task automatic hold_line(input logic level, input int clocks);
        rxd = level;
        repeat (clocks) @(posedge clk);
        #2;
    endtask

    // Start bit, nine bits MSB first, stop bit and one idle bit
    task automatic send_frame(input logic [8:0] bits, input logic stop_level);
        int bit_clocks;
        int i;
        bit_clocks = `SIR_OVERSAMPLE * cur_div;
        @(posedge clk);
        #2;
        hold_line(1'b0, bit_clocks);
        for (i = `SIR_FRAME_BITS - 1; i >= 0; i--)
            hold_line(bits[i], bit_clocks);
        hold_line(stop_level, bit_clocks);
        hold_line(1'b1, bit_clocks);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_values_test();
        logic [31:0] rdata;
        logic        err;
        read_and_check(`SIR_ADDR_CTRL, "ctrl", 0);
        read_and_check(`SIR_ADDR_DIV, "div", `SIR_DIV_RESET);
        read_and_check(`SIR_ADDR_STATUS, "status", 0);
        check("irq", 32'(irq), 0);
        check("pready", 32'(pready), 1);
        apb_read(8'h10, rdata, err);
        check("pslverr unused", 32'(err), 1);
        check("prdata unused", rdata, 0);
    endtask

    task automatic receive_random_word();
        logic [31:0] rnd;
        logic [8:0]  word;
        sir_status_t st;
        rnd  = $random(seed);
        word = rnd[8:0];
        send_frame(word, 1'b1);
        wait_valid(st);
        check("status before read", 32'(st), 1);
        read_and_check(`SIR_ADDR_DATA, "data", 32'(word));
        read_and_check(`SIR_ADDR_STATUS, "status after read", 0);
    endtask

    task automatic nine_bit_test();
        apb_write(`SIR_ADDR_CTRL, 32'h1);
        set_div(4);
        repeat (4) receive_random_word();
        set_div(7);
        repeat (4) receive_random_word();
    endtask

    task automatic parity_test();
        logic [31:0] rnd;
        logic [7:0]  byte_val;
        logic        par;
        sir_status_t st;
        set_div(`SIR_DIV_RESET);
        apb_write(`SIR_ADDR_CTRL, 32'h3);
        rnd      = $random(seed);
        byte_val = rnd[7:0];
        // Even parity makes the total count of ones even
        par      = ^byte_val;
        send_frame({byte_val, par}, 1'b1);
        wait_valid(st);
        check("status good parity", 32'(st), 1);
        check("irq masked", 32'(irq), 0);
        read_and_check(`SIR_ADDR_DATA, "data good parity", 32'(byte_val));
        send_frame({byte_val, ~par}, 1'b1);
        wait_valid(st);
        check("status bad parity", 32'(st), 9);
        check("irq masked", 32'(irq), 0);
        apb_write(`SIR_ADDR_CTRL, 32'h7);
        check("irq enabled", 32'(irq), 1);
        read_and_check(`SIR_ADDR_DATA, "data bad parity", 32'(byte_val));
        apb_write(`SIR_ADDR_STATUS, 32'h8);
        read_and_check(`SIR_ADDR_STATUS, "status parity cleared", 0);
        check("irq after clear", 32'(irq), 0);
        apb_write(`SIR_ADDR_CTRL, 32'h1);
    endtask

    task automatic framing_test();
        logic [31:0] rnd;
        logic [8:0]  word;
        sir_status_t st;
        rnd  = $random(seed);
        word = rnd[8:0];
        send_frame(word, 1'b0);
        wait_valid(st);
        check("status framing", 32'(st), 5);
        read_and_check(`SIR_ADDR_DATA, "data framing", 32'(word));
        apb_write(`SIR_ADDR_STATUS, 32'h4);
        read_and_check(`SIR_ADDR_STATUS, "status framing cleared", 0);
    endtask

    task automatic overrun_glitch_test();
        logic [31:0] rnd;
        logic [8:0]  first;
        logic [8:0]  second;
        sir_status_t st;
        int          bit_clocks;
        bit_clocks = `SIR_OVERSAMPLE * cur_div;
        rnd    = $random(seed);
        first  = rnd[8:0];
        rnd    = $random(seed);
        second = rnd[8:0];
        send_frame(first, 1'b1);
        send_frame(second, 1'b1);
        wait_valid(st);
        check("status overrun", 32'(st), 3);
        read_and_check(`SIR_ADDR_DATA, "data overrun", 32'(second));
        apb_write(`SIR_ADDR_STATUS, 32'h2);
        read_and_check(`SIR_ADDR_STATUS, "status overrun cleared", 0);

        // Quarter-bit low pulse and a whole frame time of idle line
        @(posedge clk);
        #2;
        hold_line(1'b0, bit_clocks / 4);
        hold_line(1'b1, (`SIR_FRAME_BITS + 3) * bit_clocks);
        read_and_check(`SIR_ADDR_STATUS, "status after glitch", 0);

        // Receiver disabled
        apb_write(`SIR_ADDR_CTRL, 32'h0);
        rnd = $random(seed);
        send_frame(rnd[8:0], 1'b1);
        hold_line(1'b1, bit_clocks);
        read_and_check(`SIR_ADDR_STATUS, "status while disabled", 0);
    endtask

    initial
    begin
        clk         = 1'b0;
        rstn        = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        rxd         = 1'b1;
        seed        = 32'h152;
        cur_div     = `SIR_DIV_RESET;

        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;

        reset_values_test();
        nine_bit_test();
        parity_test();
        framing_test();
        overrun_glitch_test();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
sir_pkg.sv
sir_seq_if.sv
sir_fsm.sv
sir_timer.sv
sir_shifter.sv
sir_apb_regs.sv
sir_rx_top.sv
tb_sir_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sir_rx -o tb_sir_rx_sim

# The run may stop on an error, the log decides the result
./obj_dir/tb_sir_rx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
